//--- build.f
+incdir+.
busPkg.sv
rampPkg.sv
soundRegs.sv
rampUnit.sv
rampMixer.sv
intervalTimer.sv
soundTop.sv
tbSoundTop.sv

//--- busPkg.sv
/* CPU side definitions: register offsets, write bus and decoded config structs.
   Imported by the register bank and by the top level */
package busPkg;

	// Offset inside the sound register block
	typedef logic [5:0] regOffset;

	// Mapped registers, all one byte wide
	localparam regOffset regReloadA     = 6'h1B;	// Ramp A step rate
	localparam regOffset regLimitA      = 6'h1C;
	localparam regOffset regReloadB     = 6'h22;	// Ramp B step rate
	localparam regOffset regLimitB      = 6'h23;
	localparam regOffset regMixCtrl     = 6'h24;
	localparam regOffset regTimerReload = 6'h27;
	localparam regOffset regControl     = 6'h2F;

	// One CPU write, wr is a single cycle strobe
	typedef struct packed {
		logic       wr;
		regOffset   addr;
		logic [7:0] data;
	} cpuWrite;

	// Per ramp unit settings
	typedef struct packed {
		logic [7:0] reload;	// Written value, inverted inside the ramp
		logic [7:0] limit;
	} rampCfg;

	typedef struct packed {
		logic scaleA;
		logic scaleB;
		logic subtract;	// A minus B instead of A plus B
	} mixCfg;

	typedef struct packed {
		logic [7:0] reload;
		logic       enable;
	} timerCfg;

endpackage

//--- intervalTimer.sv
/* Interval timer. A prescaler divides CLK into ticks, an 8-bit counter runs
   from the reload value to 0xFF and the timer pin toggles at each wrap */
`timescale 1ns/1ps

module intervalTimer import busPkg::*; #(
	parameter int timerPrescale = 128	// CLK cycles per tick
) (
	input  logic    CLK,
	input  logic    R86,
	input  timerCfg ctrl,
	output logic    tim
);

	localparam int preWidth = (timerPrescale > 1) ? $clog2(timerPrescale) : 1;
	localparam logic [preWidth-1:0] preLast = preWidth'(timerPrescale - 1);

	logic [preWidth-1:0] preCnt;
	logic [7:0]          timerCnt;
	logic                timQ;

	wire tick       = (preCnt == preLast);
	wire terminalCt = (timerCnt == 8'hFF);

	// Prescaler, parked at zero while stopped
	always_ff @(posedge CLK or negedge R86) begin
		if (!R86)
			preCnt <= '0;
		else if (!ctrl.enable || tick)
			preCnt <= '0;
		else
			preCnt <= preCnt + 1'b1;
	end

	// Main counter and the toggle flop
	always_ff @(posedge CLK or negedge R86) begin
		if (!R86) begin
			timerCnt <= 8'd0;
			timQ     <= 1'b1;
		end else if (!ctrl.enable) begin
			timerCnt <= ctrl.reload;	// Held at reload while stopped
			timQ     <= 1'b1;
		end else if (tick) begin
			if (terminalCt) begin
				timerCnt <= ctrl.reload;
				timQ     <= ~timQ;
			end else begin
				timerCnt <= timerCnt + 8'd1;
			end
		end
	end

	// Pin goes high in the same cycle the enable drops
	assign tim = timQ | ~ctrl.enable;

endmodule

//--- rampMixer.sv
/* Combines the two ramp levels into one registered mix word. Each operand
   may be doubled, and B may be subtracted instead of added */
`timescale 1ns/1ps

module rampMixer import busPkg::*, rampPkg::*; (
	input  logic      CLK,
	input  logic      R86,
	input  rampStatus levels,
	input  mixCfg     ctrl,
	output mix_t      mix
);

	mix_t extA;
	mix_t extB;
	mix_t opA;
	mix_t opB;

	// Zero extend both levels to the mix width
	assign extA = mix_t'(levels.levelA);
	assign extB = mix_t'(levels.levelB);

	// Optional x2 per operand
	assign opA = ctrl.scaleA ? {extA[mixWidth-2:0], 1'b0} : extA;
	assign opB = ctrl.scaleB ? {extB[mixWidth-2:0], 1'b0} : extB;

	always_ff @(posedge CLK or negedge R86) begin
		if (!R86)
			mix <= '0;
		else if (ctrl.subtract)
			mix <= opA - opB;	// Two's complement result
		else
			mix <= opA + opB;
	end

endmodule

//--- rampPkg.sv
/* Datapath widths and status types for the ramp units and the mixer */
package rampPkg;

	localparam int levelWidth = 8;
	localparam int mixWidth   = 16;

	// One envelope level
	typedef logic [levelWidth-1:0] level_t;

	// Mixer result, two's complement when subtracting
	typedef logic [mixWidth-1:0] mix_t;

	// Both ramp levels side by side
	typedef struct packed {
		level_t levelA;
		level_t levelB;
	} rampStatus;

endpackage

//--- rampUnit.sv
/* One envelope ramp. A free running reload counter sets the step rate and the
   level bounces between zero and the programmed limit */
`timescale 1ns/1ps

module rampUnit import busPkg::*, rampPkg::*; (
	input  logic   CLK,
	input  logic   R86,
	input  rampCfg cfg,
	output level_t level
);

	logic [7:0] rateCnt;	// Counts up to 0xFF then reloads
	logic       ovf;	// Registered overflow pulse
	logic       goingUp;

	wire atLimit = (level == level_t'(cfg.limit));
	wire atZero  = (level == '0);

	// Rate counter, reload of N gives one overflow every N+1 cycles
	always_ff @(posedge CLK or negedge R86) begin
		if (!R86) begin
			rateCnt <= 8'd0;
			ovf     <= 1'b0;
		end else if (rateCnt == 8'hFF) begin
			rateCnt <= ~cfg.reload;
			ovf     <= 1'b1;
		end else begin
			rateCnt <= rateCnt + 8'd1;
			ovf     <= 1'b0;
		end
	end

	// Level steps one cycle after the overflow pulse
	always_ff @(posedge CLK or negedge R86) begin
		if (!R86) begin
			level   <= '0;
			goingUp <= 1'b1;
		end else if (ovf) begin
			if (cfg.limit == 8'd0) begin
				level   <= '0;	// Frozen at zero
				goingUp <= 1'b1;
			end else if (goingUp) begin
				if (atLimit) begin
					goingUp <= 1'b0;
					level   <= level - 1'b1;
				end else begin
					// Also covers a limit lowered under the level, wraps through 0xFF
					level <= level + 1'b1;
				end
			end else begin
				if (atZero) begin
					goingUp <= 1'b1;	// Bounce off the floor
					level   <= level + 1'b1;
				end else begin
					level <= level - 1'b1;
				end
			end
		end
	end

endmodule

//--- soundRegs.sv
/* Register bank of the sound block. Latches strobed CPU writes at the mapped
   offsets and presents them as ramp, mixer and timer configuration */
`timescale 1ns/1ps

module soundRegs import busPkg::*; (
	input  logic    CLK,
	input  logic    R86,
	input  cpuWrite bus,
	output rampCfg  cfgA,
	output rampCfg  cfgB,
	output mixCfg   mixCtrl,
	output timerCfg timerCtrl
);

	// Ramp A registers
	always_ff @(posedge CLK or negedge R86) begin
		if (!R86) begin
			cfgA <= '0;
		end else if (bus.wr) begin
			if (bus.addr == regReloadA)
				cfgA.reload <= bus.data;
			if (bus.addr == regLimitA)
				cfgA.limit <= bus.data;
		end
	end

	// Ramp B registers
	always_ff @(posedge CLK or negedge R86) begin
		if (!R86) begin
			cfgB <= '0;
		end else if (bus.wr) begin
			if (bus.addr == regReloadB)
				cfgB.reload <= bus.data;
			if (bus.addr == regLimitB)
				cfgB.limit <= bus.data;
		end
	end

	// Mixer control, only three bits of the byte are kept
	always_ff @(posedge CLK or negedge R86) begin
		if (!R86) begin
			mixCtrl <= '0;
		end else if (bus.wr && bus.addr == regMixCtrl) begin
			mixCtrl.scaleA   <= bus.data[5];
			mixCtrl.scaleB   <= bus.data[1];
			mixCtrl.subtract <= bus.data[0];
		end
	end

	// Timer reload and the enable from the control register
	always_ff @(posedge CLK or negedge R86) begin
		if (!R86) begin
			timerCtrl <= '0;
		end else if (bus.wr) begin
			case (bus.addr)
				regTimerReload: timerCtrl.reload <= bus.data;
				regControl:     timerCtrl.enable <= bus.data[5];	// Timer run bit
				default: ;	// Unmapped offsets fall through
			endcase
		end
	end

endmodule

//--- soundTop.sv
/* Top of the envelope ramp section: register bank, two ramp units, the
   mixer and the interval timer. Prescale of the timer is set here */
`timescale 1ns/1ps

module soundTop import busPkg::*, rampPkg::*; #(
	parameter int timerPrescale = 128
) (
	input  logic      CLK,
	input  logic      R86,
	input  cpuWrite   bus,
	output mix_t      mix,
	output rampStatus levels,
	output logic      tim
);

	rampCfg  cfgA;
	rampCfg  cfgB;
	mixCfg   mixCtrl;
	timerCfg timerCtrl;
	level_t  levelA;
	level_t  levelB;

	soundRegs regs (
		.CLK       (CLK),
		.R86       (R86),
		.bus       (bus),
		.cfgA      (cfgA),
		.cfgB      (cfgB),
		.mixCtrl   (mixCtrl),
		.timerCtrl (timerCtrl)
	);

	// Two identical ramps run side by side
	rampUnit rampA (
		.CLK   (CLK),
		.R86   (R86),
		.cfg   (cfgA),
		.level (levelA)
	);

	rampUnit rampB (
		.CLK   (CLK),
		.R86   (R86),
		.cfg   (cfgB),
		.level (levelB)
	);

	assign levels = '{levelA: levelA, levelB: levelB};

	rampMixer mixer (
		.CLK    (CLK),
		.R86    (R86),
		.levels (levels),
		.ctrl   (mixCtrl),
		.mix    (mix)
	);

	intervalTimer #(
		.timerPrescale (timerPrescale)
	) timer (
		.CLK  (CLK),
		.R86  (R86),
		.ctrl (timerCtrl),
		.tim  (tim)
	);

endmodule

//--- tbModel.svh
/* Cycle model of the sound block, included inside the testbench module.
   clearModel at reset release, then stepModel once per rising CLK edge */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Register copies, index 0 is ramp A
logic [7:0]  rReload [2];
logic [7:0]  rLimit [2];
logic        rScaleA;
logic        rScaleB;
logic        rSub;
logic [7:0]  rTimReload;
logic        rTimEn;

// Ramp state per unit
logic [7:0]  mCnt [2];
logic        mOvf [2];	// Overflow seen on the previous edge
logic [7:0]  mLevel [2];
logic        mUp [2];

logic [15:0] mMix;
int          mPre;	// Prescale phase of the timer
logic [7:0]  mTimCnt;
logic        mTimQ;

task automatic clearModel();
	int u;
	for (u = 0; u < 2; u++) begin
		rReload[u] = 8'h00;
		rLimit[u]  = 8'h00;
		mCnt[u]    = 8'h00;
		mOvf[u]    = 1'b0;
		mLevel[u]  = 8'h00;
		mUp[u]     = 1'b1;
	end
	rScaleA    = 1'b0;
	rScaleB    = 1'b0;
	rSub       = 1'b0;
	rTimReload = 8'h00;
	rTimEn     = 1'b0;
	mMix       = 16'h0000;
	mPre       = 0;
	mTimCnt    = 8'h00;
	mTimQ      = 1'b1;
endtask

// Everything below reads the state from before the edge
task automatic stepModel(input cpuWrite w);
	logic [15:0] opA;
	logic [15:0] opB;
	int u;
	opA  = {8'h00, mLevel[0]} << rScaleA;
	opB  = {8'h00, mLevel[1]} << rScaleB;
	mMix = rSub ? opA - opB : opA + opB;
	for (u = 0; u < 2; u++) begin
		if (mOvf[u]) begin
			if (rLimit[u] == 8'h00) begin
				mLevel[u] = 8'h00;
				mUp[u]    = 1'b1;
			end else if (mUp[u]) begin
				if (mLevel[u] == rLimit[u]) begin
					mUp[u]    = 1'b0;
					mLevel[u] = mLevel[u] - 8'h01;
				end else begin
					mLevel[u] = mLevel[u] + 8'h01;	// May wrap through 0xFF
				end
			end else if (mLevel[u] == 8'h00) begin
				mUp[u]    = 1'b1;
				mLevel[u] = 8'h01;
			end else begin
				mLevel[u] = mLevel[u] - 8'h01;
			end
		end
		mOvf[u] = (mCnt[u] == 8'hFF);
		mCnt[u] = mOvf[u] ? ~rReload[u] : mCnt[u] + 8'h01;
	end
	if (!rTimEn) begin
		mPre    = 0;
		mTimCnt = rTimReload;
		mTimQ   = 1'b1;
	end else if (mPre == prescale - 1) begin
		mPre = 0;
		if (mTimCnt == 8'hFF) begin
			mTimCnt = rTimReload;
			mTimQ   = ~mTimQ;	// Toggle on the wrap tick
		end else begin
			mTimCnt = mTimCnt + 8'h01;
		end
	end else begin
		mPre++;
	end
	if (w.wr) begin
		case (w.addr)
			regReloadA:     rReload[0] = w.data;
			regLimitA:      rLimit[0] = w.data;
			regReloadB:     rReload[1] = w.data;
			regLimitB:      rLimit[1] = w.data;
			regMixCtrl: begin
				rScaleA = w.data[5];
				rScaleB = w.data[1];
				rSub    = w.data[0];
			end
			regTimerReload: rTimReload = w.data;
			regControl:     rTimEn = w.data[5];
			default: ;
		endcase
	end
endtask

`endif

//--- tbSoundTop.sv
/* Testbench for soundTop. Random register writes are replayed on a cycle
   model and mix, levels and tim are compared on every falling edge */
`timescale 1ns/1ps

module tbSoundTop import busPkg::*, rampPkg::*; ();

	localparam int prescale  = 4;
	// Planned cycles per test
	localparam int lenReset  = 300;
	localparam int lenRate   = 1700;
	localparam int lenBounce = 1200;
	localparam int lenMix    = 800;
	localparam int lenTimer  = 700;
	localparam int lenIgnore = 850;
	localparam int timeoutLimit =
		(lenReset + lenRate + lenBounce + lenMix + lenTimer + lenIgnore) * 11 / 10;

	logic      CLK;
	logic      R86;
	cpuWrite   bus;
	mix_t      mix;
	rampStatus levels;
	logic      tim;

	cpuWrite applied;	// Bus value the DUT takes at the next edge
	integer  seed;
	int      errorCount;
	int      checkCount;
	int      sinceRelease;	// Edges since reset release
	int      cycleCount;

	`include "tbModel.svh"

	soundTop #(
		.timerPrescale (prescale)
	) DUT (
		.CLK    (CLK),
		.R86    (R86),
		.bus    (bus),
		.mix    (mix),
		.levels (levels),
		.tim    (tim)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	function automatic int randBelow(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic cpuWrite makeWrite(input logic wr, input regOffset a, input logic [7:0] d);
		cpuWrite w;
		w.wr   = wr;
		w.addr = a;
		w.data = d;
		return w;
	endfunction

	function automatic logic isMapped(input regOffset a);
		case (a)
			regReloadA, regLimitA, regReloadB, regLimitB,
			regMixCtrl, regTimerReload, regControl: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	task automatic checkOutputs();
		logic expTim;
		expTim = rTimEn ? mTimQ : 1'b1;	// Pin held high while the timer is off
		checkCount++;
		assert (mix === mMix) else begin
			$display("Fail mix expected %h actual %h", mMix, mix);
			errorCount++;
		end
		assert (levels.levelA === mLevel[0]) else begin
			$display("Fail levels.levelA expected %h actual %h", mLevel[0], levels.levelA);
			errorCount++;
		end
		assert (levels.levelB === mLevel[1]) else begin
			$display("Fail levels.levelB expected %h actual %h", mLevel[1], levels.levelB);
			errorCount++;
		end
		assert (tim === expTim) else begin
			$display("Fail tim expected %h actual %h", expTim, tim);
			errorCount++;
		end
	endtask

	// Model takes the edge and the next bus value goes out before the check
	task automatic doCycle(input cpuWrite next);
		@(posedge CLK);
		stepModel(applied);
		bus <= next;
		applied = next;
		sinceRelease++;
		@(negedge CLK);
		checkOutputs();
	endtask

	task automatic idle(input int n);
		repeat (n) doCycle('0);
	endtask

	// Strobed write followed by a short random gap
	task automatic writeReg(input regOffset a, input logic [7:0] d);
		doCycle(makeWrite(1'b1, a, d));
		idle(randBelow(4));
	endtask

	task automatic applyReset();
		repeat (3) @(posedge CLK);
		R86 <= 1'b1;
		clearModel();
		applied = '0;
		sinceRelease = 0;
		@(negedge CLK);
	endtask

	task automatic finishTest(input string name, input int errStart);
		if (errorCount == errStart)
			$display("Test %s: passed", name);
		else
			$display("Test %s: %0d errors", name, errorCount - errStart);
	endtask

	task automatic checkReset();
		applyReset();
		assert (mix === 16'h0000) else begin
			$display("Fail mix expected %h actual %h", 16'h0000, mix);
			errorCount++;
		end
		assert (levels === 16'h0000) else begin
			$display("Fail levels expected %h actual %h", 16'h0000, levels);
			errorCount++;
		end
		assert (tim === 1'b1) else begin
			$display("Fail tim expected %h actual %h", 1'b1, tim);
			errorCount++;
		end
		writeReg(regLimitA, 8'h10);	// Nonzero limit so the first step shows
		writeReg(regLimitB, 8'h10);
		while (levels.levelA === 8'h00 && sinceRelease < lenReset)
			doCycle('0);
		assert (sinceRelease == 257) else begin
			$display("First ramp step came %0d cycles after reset, expected 257", sinceRelease);
			errorCount++;
		end
	endtask

	task automatic stepRates();
		int seg;
		writeReg(regLimitA, 8'hFF);
		writeReg(regLimitB, 8'hFF);
		for (seg = 0; seg < 4; seg++) begin
			writeReg(regReloadA, 8'(randBelow(24)));
			writeReg(regReloadB, 8'(randBelow(24)));
			idle(400);
		end
	endtask

	task automatic bounceLimits();
		int seg;
		for (seg = 0; seg < 6; seg++) begin
			writeReg(regLimitA, 8'(randBelow(7) + 1));
			writeReg(regLimitB, 8'(randBelow(7) + 1));
			writeReg(regReloadA, 8'(randBelow(4)));
			writeReg(regReloadB, 8'(randBelow(4)));
			idle(150);
		end
		writeReg(regLimitA, 8'h00);
		idle(40);
		assert (levels.levelA === 8'h00) else begin
			$display("Fail levels.levelA expected %h actual %h", 8'h00, levels.levelA);
			errorCount++;
		end
	endtask

	task automatic mixModes();
		int seg;
		writeReg(regLimitA, 8'h80 | 8'(randBelow(128)));
		writeReg(regLimitB, 8'h80 | 8'(randBelow(128)));
		writeReg(regReloadA, 8'(randBelow(8)));
		writeReg(regReloadB, 8'(randBelow(8)));
		for (seg = 0; seg < 16; seg++) begin
			writeReg(regMixCtrl, 8'(randBelow(256)));
			idle(40);
		end
	endtask

	task automatic timerPeriods();
		int round;
		int n;
		int period;
		int lastToggle;
		int toggles;
		logic [7:0] reload;
		logic prevTim;
		for (round = 0; round < 3; round++) begin
			reload = 8'hF0 + 8'(randBelow(16));	// Keeps periods short
			period = (256 - reload) * prescale;
			writeReg(regTimerReload, reload);
			writeReg(regControl, 8'h20 | 8'(randBelow(256)));
			prevTim = tim;
			lastToggle = -1;
			toggles = 0;
			for (n = 0; n < 3 * period + 8; n++) begin
				doCycle('0);
				if (tim !== prevTim) begin
					if (lastToggle >= 0) begin
						assert (sinceRelease - lastToggle == period) else begin
							$display("Timer toggled after %0d cycles, expected %0d",
								sinceRelease - lastToggle, period);
							errorCount++;
						end
					end
					lastToggle = sinceRelease;
					prevTim = tim;
					toggles++;
				end
			end
			assert (toggles >= 3) else begin
				$display("Timer toggled only %0d times while enabled", toggles);
				errorCount++;
			end
			doCycle(makeWrite(1'b1, regControl, 8'(randBelow(256)) & 8'hDF));
			doCycle('0);	// Edge that takes the disable
			assert (tim === 1'b1) else begin
				$display("Fail tim expected %h actual %h", 1'b1, tim);
				errorCount++;
			end
		end
	endtask

	task automatic unmappedWrites();
		int n;
		regOffset a;
		for (n = 0; n < 200; n++) begin
			a = regOffset'(randBelow(64));
			while (isMapped(a))
				a = regOffset'(randBelow(64));
			writeReg(a, 8'(randBelow(256)));
		end
		// Mapped offset but no strobe, a stored byte would show on mix
		for (n = 0; n < 20; n++)
			doCycle(makeWrite(1'b0, regMixCtrl, 8'(randBelow(256))));
	endtask

	initial begin
		cycleCount = 0;
		while (cycleCount < timeoutLimit) begin
			@(posedge CLK);
			cycleCount++;
		end
		$display("Timeout: the run went past %0d cycles without finishing", timeoutLimit);
		$display("Finished with errors");
		$finish;
	end

	initial begin
		int errStart;
		seed = 55768;
		R86 = 1'b0;
		bus = '0;
		applied = '0;
		errorCount = 0;
		checkCount = 0;
		sinceRelease = 0;
		clearModel();

		errStart = errorCount;
		checkReset();
		finishTest("reset state", errStart);
		errStart = errorCount;
		stepRates();
		finishTest("step rate", errStart);
		errStart = errorCount;
		bounceLimits();
		finishTest("bounce", errStart);
		errStart = errorCount;
		mixModes();
		finishTest("mixing", errStart);
		errStart = errorCount;
		timerPeriods();
		finishTest("timer", errStart);
		errStart = errorCount;
		unmappedWrites();
		finishTest("ignored writes", errStart);

		$display("Cycles checked %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule
